/* rtl/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  alu_op_t;

    // alu selectors
    localparam alu_op_t ALU_ADD    = 3'd0;
    localparam alu_op_t ALU_SUB    = 3'd1;
    localparam alu_op_t ALU_AND    = 3'd2;
    localparam alu_op_t ALU_OR     = 3'd3;
    localparam alu_op_t ALU_XOR    = 3'd4;
    localparam alu_op_t ALU_PASS_B = 3'd5;

    // major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 values
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // ecall has a single legal encoding
    localparam word_t INST_ECALL = 32'h0000_0073;

endpackage

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire core_pkg::reg_idx_t rs1_idx,
    input  wire core_pkg::reg_idx_t rs2_idx,
    output core_pkg::word_t         rs1_data,
    output core_pkg::word_t         rs2_data,
    input  wire core_pkg::reg_idx_t rd_idx,
    input  wire                     rd_wen,
    input  wire core_pkg::word_t    rd_data,
    output core_pkg::word_t         gp
);

    // x0 has no storage
    core_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && (rd_idx != 5'd0)) begin
            regs[rd_idx] <= rd_data;
        end
    end

    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];
    assign gp       = regs[3];

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                     id_valid,
    input  wire core_pkg::word_t    id_inst,
    input  wire core_pkg::word_t    id_pc,
    input  wire core_pkg::word_t    rs1_data,
    input  wire core_pkg::word_t    rs2_data,
    input  wire core_pkg::reg_idx_t exe_rd,
    input  wire                     exe_rf_wen,
    input  wire core_pkg::reg_idx_t mem_rd,
    input  wire                     mem_rf_wen,
    input  wire core_pkg::reg_idx_t wb_rd,
    input  wire                     wb_rf_wen,
    output core_pkg::reg_idx_t      rs1_idx,
    output core_pkg::reg_idx_t      rs2_idx,
    output logic                    dec_valid,
    output core_pkg::word_t         dec_pc,
    output core_pkg::word_t         dec_op_a,
    output core_pkg::word_t         dec_op_b,
    output core_pkg::word_t         dec_store_data,
    output core_pkg::word_t         dec_imm,
    output core_pkg::alu_op_t       dec_alu_op,
    output core_pkg::reg_idx_t      dec_rd,
    output logic                    dec_rf_wen,
    output logic                    dec_mem_ren,
    output logic                    dec_mem_wen,
    output logic                    dec_branch,
    output logic                    dec_branch_ne,
    output logic                    dec_jal,
    output logic                    dec_exit,
    output logic                    hazard_stall
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
    logic            use_rs1, use_rs2, rf_wen, rs1_busy, rs2_busy;

    function automatic logic pending(input core_pkg::reg_idx_t src,
                                     input core_pkg::reg_idx_t dst, input logic wen);
        return wen && (src != 5'd0) && (src == dst);
    endfunction

    assign opcode  = id_inst[6:0];
    assign funct3  = id_inst[14:12];
    assign funct7  = id_inst[31:25];
    assign rs1_idx = id_inst[19:15];
    assign rs2_idx = id_inst[24:20];
    assign dec_rd  = id_inst[11:7];

    assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
    assign imm_s = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
    assign imm_b = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};
    assign imm_u = {id_inst[31:12], 12'b0};
    assign imm_j = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                    id_inst[30:21], 1'b0};

    always_comb begin
        use_rs1       = 1'b0;
        use_rs2       = 1'b0;
        rf_wen        = 1'b0;
        dec_op_a      = rs1_data;
        dec_op_b      = rs2_data;
        dec_imm       = '0;
        dec_alu_op    = core_pkg::ALU_ADD;
        dec_mem_ren   = 1'b0;
        dec_mem_wen   = 1'b0;
        dec_branch    = 1'b0;
        dec_branch_ne = 1'b0;
        dec_jal       = 1'b0;
        dec_exit      = 1'b0;
        case (opcode)
            core_pkg::OP_REG: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                rf_wen  = 1'b1;
                case ({funct7, funct3})
                    {core_pkg::F7_BASE, core_pkg::F3_ADD_SUB}: dec_alu_op = core_pkg::ALU_ADD;
                    {core_pkg::F7_SUB, core_pkg::F3_ADD_SUB}:  dec_alu_op = core_pkg::ALU_SUB;
                    {core_pkg::F7_BASE, core_pkg::F3_XOR}:     dec_alu_op = core_pkg::ALU_XOR;
                    {core_pkg::F7_BASE, core_pkg::F3_OR}:      dec_alu_op = core_pkg::ALU_OR;
                    {core_pkg::F7_BASE, core_pkg::F3_AND}:     dec_alu_op = core_pkg::ALU_AND;
                    default:                                   rf_wen = 1'b0;
                endcase
            end
            core_pkg::OP_IMM: begin
                // only addi
                use_rs1  = (funct3 == core_pkg::F3_ADD_SUB);
                rf_wen   = (funct3 == core_pkg::F3_ADD_SUB);
                dec_op_b = imm_i;
            end
            core_pkg::OP_LUI: begin
                rf_wen     = 1'b1;
                dec_op_b   = imm_u;
                dec_alu_op = core_pkg::ALU_PASS_B;
            end
            core_pkg::OP_LOAD: begin
                use_rs1     = (funct3 == core_pkg::F3_WORD);
                rf_wen      = (funct3 == core_pkg::F3_WORD);
                dec_mem_ren = (funct3 == core_pkg::F3_WORD);
                dec_op_b    = imm_i;
            end
            core_pkg::OP_STORE: begin
                use_rs1     = (funct3 == core_pkg::F3_WORD);
                use_rs2     = (funct3 == core_pkg::F3_WORD);
                dec_mem_wen = (funct3 == core_pkg::F3_WORD);
                dec_op_b    = imm_s;
            end
            core_pkg::OP_BRANCH: begin
                if (funct3 == core_pkg::F3_BEQ || funct3 == core_pkg::F3_BNE) begin
                    use_rs1       = 1'b1;
                    use_rs2       = 1'b1;
                    dec_branch    = 1'b1;
                    dec_branch_ne = (funct3 == core_pkg::F3_BNE);
                    dec_imm       = imm_b;
                end
            end
            core_pkg::OP_JAL: begin
                // link value is pc + 4 through the adder
                rf_wen   = 1'b1;
                dec_jal  = 1'b1;
                dec_op_a = id_pc;
                dec_op_b = 32'd4;
                dec_imm  = imm_j;
            end
            core_pkg::OP_SYSTEM: dec_exit = (id_inst == core_pkg::INST_ECALL);
            default: ;
        endcase
    end

    assign rs1_busy = pending(rs1_idx, exe_rd, exe_rf_wen) ||
                      pending(rs1_idx, mem_rd, mem_rf_wen) ||
                      pending(rs1_idx, wb_rd, wb_rf_wen);
    assign rs2_busy = pending(rs2_idx, exe_rd, exe_rf_wen) ||
                      pending(rs2_idx, mem_rd, mem_rf_wen) ||
                      pending(rs2_idx, wb_rd, wb_rf_wen);

    assign hazard_stall   = id_valid && ((use_rs1 && rs1_busy) || (use_rs2 && rs2_busy));
    assign dec_valid      = id_valid && !hazard_stall;
    assign dec_rf_wen     = rf_wen && (dec_rd != 5'd0);
    assign dec_pc         = id_pc;
    assign dec_store_data = rs2_data;

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                    exe_valid,
    input  wire core_pkg::word_t   exe_pc,
    input  wire core_pkg::word_t   exe_op_a,
    input  wire core_pkg::word_t   exe_op_b,
    input  wire core_pkg::word_t   exe_imm,
    input  wire core_pkg::alu_op_t exe_alu_op,
    input  wire                    exe_branch,
    input  wire                    exe_branch_ne,
    input  wire                    exe_jal,
    input  wire core_pkg::word_t   exe_rs1_val,
    input  wire core_pkg::word_t   exe_rs2_val,
    output core_pkg::word_t        alu_out,
    output logic                   branch_taken,
    output core_pkg::word_t        branch_target
);

    logic cond_met;

    always_comb begin
        case (exe_alu_op)
            core_pkg::ALU_SUB:    alu_out = exe_op_a - exe_op_b;
            core_pkg::ALU_AND:    alu_out = exe_op_a & exe_op_b;
            core_pkg::ALU_OR:     alu_out = exe_op_a | exe_op_b;
            core_pkg::ALU_XOR:    alu_out = exe_op_a ^ exe_op_b;
            core_pkg::ALU_PASS_B: alu_out = exe_op_b;
            default:              alu_out = exe_op_a + exe_op_b;
        endcase
    end

    // bne inverts the equality test
    assign cond_met = (exe_rs1_val == exe_rs2_val) ^ exe_branch_ne;

    assign branch_taken  = exe_valid && (exe_jal || (exe_branch && cond_met));
    assign branch_target = exe_pc + exe_imm;

endmodule

`default_nettype wire

/* rtl/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  mem_valid,
    input  wire                  mem_ren,
    input  wire                  mem_wen,
    input  wire core_pkg::word_t mem_addr,
    input  wire core_pkg::word_t mem_store_data,
    input  wire core_pkg::word_t wb_dat_r,
    input  wire                  wb_ack,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output core_pkg::word_t      wb_adr,
    output core_pkg::word_t      wb_dat_w,
    output core_pkg::word_t      load_data,
    output logic                 mem_stall
);

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DONE
    } mem_state_t;

    mem_state_t state;
    logic       access;

    assign access    = mem_valid && (mem_ren || mem_wen);
    // done frees the pipeline for exactly one cycle
    assign mem_stall = ((state == IDLE) && access) || (state == BUS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (access) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        state  <= BUS;
                    end
                end
                BUS: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        state  <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request fields latched at issue, held through the wait
    always_ff @(posedge clk) begin
        if ((state == IDLE) && access) begin
            wb_we    <= mem_wen;
            wb_adr   <= mem_addr;
            wb_dat_w <= mem_store_data;
        end
        if ((state == BUS) && wb_ack) begin
            load_data <= wb_dat_r;
        end
    end

endmodule

`default_nettype wire

/* rtl/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  wire                  clk,
    input  wire                  rst_n,
    output core_pkg::word_t      imem_addr,
    input  wire core_pkg::word_t imem_data,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output core_pkg::word_t      wb_adr,
    output core_pkg::word_t      wb_dat_w,
    input  wire core_pkg::word_t wb_dat_r,
    input  wire                  wb_ack,
    output logic                 exit,
    output core_pkg::word_t      gp
);

    core_pkg::word_t    pc;
    logic               id_valid;
    core_pkg::word_t    id_inst, id_pc;

    core_pkg::reg_idx_t rs1_idx, rs2_idx;
    core_pkg::word_t    rs1_data, rs2_data;
    logic               dec_valid, hazard_stall;
    core_pkg::word_t    dec_pc, dec_op_a, dec_op_b, dec_store_data, dec_imm;
    core_pkg::alu_op_t  dec_alu_op;
    core_pkg::reg_idx_t dec_rd;
    logic dec_rf_wen, dec_mem_ren, dec_mem_wen, dec_branch, dec_branch_ne, dec_jal, dec_exit;

    logic               exe_valid;
    core_pkg::word_t    exe_pc, exe_op_a, exe_op_b, exe_store_data, exe_imm;
    core_pkg::alu_op_t  exe_alu_op;
    core_pkg::reg_idx_t exe_rd;
    logic exe_rf_wen, exe_mem_ren, exe_mem_wen, exe_branch, exe_branch_ne, exe_jal, exe_exit;
    core_pkg::word_t    alu_out, branch_target;
    logic               branch_taken;

    logic               mem_valid, mem_rf_wen, mem_ren, mem_wen, mem_exit, mem_stall;
    core_pkg::reg_idx_t mem_rd;
    core_pkg::word_t    mem_alu_out, mem_store_data, load_data;

    logic               wb_valid, wb_rf_wen, wb_mem_ren, wb_exit;
    core_pkg::reg_idx_t wb_rd;
    core_pkg::word_t    wb_alu_out, wb_load_data, wb_data;

    logic exe_stall, id_stall, if_stall, redirect, freeze;

    assign exe_stall = mem_stall;
    assign id_stall  = exe_stall;
    assign if_stall  = id_stall || hazard_stall;
    // a taken branch waits in exe while memory is busy
    assign redirect  = branch_taken && !exe_stall;
    // retired ecall parks in wb and stops everything behind it
    assign freeze    = exit || (wb_valid && wb_exit);
    assign imem_addr = pc;
    assign wb_data   = wb_mem_ren ? wb_load_data : wb_alu_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= RESET_PC;
            id_valid  <= 1'b0;
            exe_valid <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
            exit      <= 1'b0;
        end else begin
            if (wb_valid && wb_exit) begin
                exit <= 1'b1;
            end
            if (!freeze) begin
                if (redirect) begin
                    pc       <= branch_target;
                    id_valid <= 1'b0;
                end else if (!if_stall) begin
                    pc       <= pc + 32'd4;
                    id_valid <= 1'b1;
                end
                if (!exe_stall) begin
                    exe_valid <= dec_valid && !redirect;
                    mem_valid <= exe_valid;
                end
                wb_valid <= mem_valid && !mem_stall;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            if (!if_stall) begin
                id_inst <= imem_data;
                id_pc   <= pc;
            end
            if (!exe_stall) begin
                exe_pc         <= dec_pc;
                exe_op_a       <= dec_op_a;
                exe_op_b       <= dec_op_b;
                exe_store_data <= dec_store_data;
                exe_imm        <= dec_imm;
                exe_alu_op     <= dec_alu_op;
                exe_rd         <= dec_rd;
                exe_rf_wen     <= dec_rf_wen;
                exe_mem_ren    <= dec_mem_ren;
                exe_mem_wen    <= dec_mem_wen;
                exe_branch     <= dec_branch;
                exe_branch_ne  <= dec_branch_ne;
                exe_jal        <= dec_jal;
                exe_exit       <= dec_exit;
                mem_rd         <= exe_rd;
                mem_rf_wen     <= exe_rf_wen;
                mem_ren        <= exe_mem_ren;
                mem_wen        <= exe_mem_wen;
                mem_alu_out    <= alu_out;
                mem_store_data <= exe_store_data;
                mem_exit       <= exe_exit;
            end
            wb_rd        <= mem_rd;
            wb_rf_wen    <= mem_rf_wen;
            wb_mem_ren   <= mem_ren;
            wb_alu_out   <= mem_alu_out;
            wb_load_data <= load_data;
            wb_exit      <= mem_exit;
        end
    end

    decode_stage u_decode (
        .*,
        .exe_rf_wen (exe_valid && exe_rf_wen),
        .mem_rf_wen (mem_valid && mem_rf_wen),
        .wb_rf_wen  (wb_valid && wb_rf_wen)
    );

    // branch compare uses operand a and the store data, both raw register values
    execute_stage u_execute (
        .*,
        .exe_rs1_val (exe_op_a),
        .exe_rs2_val (exe_store_data)
    );

    memory_stage u_memory (
        .*,
        .mem_valid (mem_valid && !freeze),
        .mem_addr  (mem_alu_out)
    );

    register_file u_regfile (
        .*,
        .rd_idx  (wb_rd),
        .rd_wen  (wb_valid && wb_rf_wen),
        .rd_data (wb_data)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n,
    input  wire  reset_req
);

    int cnt = 0;

    initial begin
        clk = 1'b0;
    end

    // 40 ns period
    always #20 clk = ~clk;

    // reset held for 8 rising edges after power-up or a request
    always @(posedge clk) begin
        if (reset_req) begin
            cnt <= 0;
        end else if (cnt < 8) begin
            cnt <= cnt + 1;
        end
    end

    assign rst_n = (cnt == 8) && !reset_req;

endmodule

`default_nettype wire

/* testbench/core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module core_asserts (
    input wire        clk,
    input wire        rst_n,
    input wire        wb_cyc,
    input wire        wb_stb,
    input wire        wb_we,
    input wire [31:0] wb_adr,
    input wire [31:0] wb_dat_w,
    input wire        wb_ack
);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc)
        else $error("wishbone strobe raised without cycle");

    // request must not move while the slave is still waiting
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
        else $error("wishbone request changed before ack");

    stb_drops: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && wb_ack) |=> !wb_stb)
        else $error("wishbone strobe still high in the cycle after ack");

endmodule

bind memory_stage core_asserts u_asserts (.*);

`default_nettype wire

/* testbench/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [31:0] NOP      = 32'h0000_0013;
    localparam int LAST = 39;
    localparam int TIMEOUT = 2000;

    logic        clk, rst_n, reset_req, wb_cyc, wb_stb, wb_we, wb_ack, exit, random_wait, busy;
    logic [31:0] imem_addr, imem_data, wb_adr, wb_dat_w, wb_dat_r, gp, exp_gp;
    logic [31:0] lfsr_state = 32'h28c555cc;
    logic [31:0] rom [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] f_imm [0:LAST];
    logic [4:0]  f_rd [0:LAST];
    logic [4:0]  f_rs1 [0:LAST];
    logic [4:0]  f_rs2 [0:LAST];
    int          kind [0:LAST];
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    int exp_writes, write_count, test_errors, tests_run, tests_failed, wait_left;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n), .reset_req(reset_req));

    core_top #(.RESET_PC(32'h0)) uut (.*);

    assign imem_data = (imem_addr < 32'd256) ? rom[imem_addr[7:2]] : NOP;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // initial data memory content, a hash of the byte address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // x0..x7 only, so that dependent chains are common
    task automatic build_program();
        logic [31:0] t;
        logic [2:0]  f3;
        int          off_w;
        for (int i = 0; i < 64; i++) begin
            rom[i] = NOP;
        end
        for (int i = 0; i < LAST; i++) begin
            t = rand_bits(4);
            kind[i] = int'(t[3:0]);
            t = rand_bits(9);
            f_rd[i]  = {2'b00, t[2:0]};
            f_rs1[i] = {2'b00, t[5:3]};
            f_rs2[i] = {2'b00, t[8:6]};
            off_w = 1 + int'(rand_bits(2));
            if (off_w > LAST - i) begin
                off_w = LAST - i;
            end
            f_imm[i] = 32'(off_w * 4);
            case (kind[i])
                0, 1, 2, 3, 4: begin
                    f3 = (kind[i] == 2) ? 3'b111 : (kind[i] == 3) ? 3'b110 :
                         (kind[i] == 4) ? 3'b100 : 3'b000;
                    rom[i] = {(kind[i] == 1) ? 7'b0100000 : 7'b0000000, f_rs2[i], f_rs1[i],
                              f3, f_rd[i], OP_REG};
                end
                7: begin
                    t = rand_bits(20);
                    f_imm[i] = {t[19:0], 12'b0};
                    rom[i] = {t[19:0], f_rd[i], OP_LUI};
                end
                8, 9: begin
                    t = rand_bits(6);
                    f_imm[i] = {24'b0, t[5:0], 2'b00};
                    rom[i] = {f_imm[i][11:0], 5'd0, 3'b010, f_rd[i], OP_LOAD};
                end
                10, 11: begin
                    t = rand_bits(6);
                    f_imm[i] = {24'b0, t[5:0], 2'b00};
                    rom[i] = {f_imm[i][11:5], f_rs2[i], 5'd0, 3'b010, f_imm[i][4:0], OP_STORE};
                end
                12, 13: rom[i] = enc_b(f_imm[i][12:0], f_rs2[i], f_rs1[i],
                                       (kind[i] == 12) ? 3'b000 : 3'b001);
                14: rom[i] = enc_j(f_imm[i][20:0], f_rd[i]);
                default: begin
                    t = rand_bits(12);
                    f_imm[i] = {{20{t[11]}}, t[11:0]};
                    rom[i] = {t[11:0], f_rs1[i], 3'b000, f_rd[i], OP_IMM};
                end
            endcase
        end
        kind[LAST] = 16;
        rom[LAST]  = 32'h0000_0073;
        // younger work that the ecall must keep from retiring
        rom[LAST + 1] = {12'd1, 5'd3, 3'b000, 5'd3, OP_IMM};
        rom[LAST + 2] = {7'd0, 5'd3, 5'd0, 3'b010, 5'd0, OP_STORE};
    endtask

    // instruction-level model, runs until the ecall
    task automatic run_model();
        logic [31:0] regs [0:31];
        logic [31:0] m [0:63];
        logic [31:0] a, b;
        int          pc, nxt;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            m[i] = fill_word(32'(i * 4));
        end
        exp_adr.delete();
        exp_dat.delete();
        pc = 0;
        while (kind[pc] != 16) begin
            a = regs[f_rs1[pc]];
            b = regs[f_rs2[pc]];
            nxt = pc + 1;
            case (kind[pc])
                0: regs[f_rd[pc]] = a + b;
                1: regs[f_rd[pc]] = a - b;
                2: regs[f_rd[pc]] = a & b;
                3: regs[f_rd[pc]] = a | b;
                4: regs[f_rd[pc]] = a ^ b;
                7: regs[f_rd[pc]] = f_imm[pc];
                8, 9: regs[f_rd[pc]] = m[f_imm[pc][7:2]];
                10, 11: begin
                    m[f_imm[pc][7:2]] = b;
                    exp_adr.push_back(f_imm[pc]);
                    exp_dat.push_back(b);
                end
                12, 13: begin
                    if ((a == b) == (kind[pc] == 12)) begin
                        nxt = pc + int'(f_imm[pc] >> 2);
                    end
                end
                14: begin
                    regs[f_rd[pc]] = 32'(pc * 4 + 4);
                    nxt = pc + int'(f_imm[pc] >> 2);
                end
                default: regs[f_rd[pc]] = a + f_imm[pc];
            endcase
            regs[0] = '0;
            pc = nxt;
        end
        exp_gp = regs[3];
        exp_writes = exp_adr.size();
    endtask

    // wishbone slave, answers on the falling edge
    always @(negedge clk) begin
        if (wb_ack) begin
            wb_ack <= 1'b0;
            busy = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy = 1'b1;
                wait_left = random_wait ? int'(rand_bits(2)) : 0;
            end
            if (wait_left == 0) begin
                wb_ack <= 1'b1;
                if (wb_we) begin
                    dmem[wb_adr[7:2]] <= wb_dat_w;
                end else begin
                    wb_dat_r <= dmem[wb_adr[7:2]];
                end
            end else begin
                wait_left--;
            end
        end
    end

    // store checker
    always @(posedge clk) begin
        if (rst_n && wb_cyc && wb_stb && wb_ack && wb_we) begin
            write_count++;
            if (exp_adr.size() == 0) begin
                $display("unexpected extra write at %0t to %h", $time, wb_adr);
                test_errors++;
            end else begin
                assert (wb_adr == exp_adr[0]) else begin
                    $display("MISMATCH at %0t: wb_adr got %h expected %h",
                             $time, wb_adr, exp_adr[0]);
                    test_errors++;
                end
                assert (wb_dat_w == exp_dat[0]) else begin
                    $display("MISMATCH at %0t: wb_dat_w got %h expected %h",
                             $time, wb_dat_w, exp_dat[0]);
                    test_errors++;
                end
                void'(exp_adr.pop_front());
                void'(exp_dat.pop_front());
            end
        end
    end

    task automatic run_test(input int prog, input logic rnd);
        int cycles;
        test_errors = 0;
        write_count = 0;
        random_wait = rnd;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(32'(i * 4));
        end
        run_model();
        @(negedge clk);
        reset_req = 1'b1;
        @(negedge clk);
        reset_req = 1'b0;
        assert (imem_addr == 32'h0) else begin
            $display("MISMATCH at %0t: imem_addr got %h expected %h",
                     $time, imem_addr, 32'h0);
            test_errors++;
        end
        assert ({wb_cyc, wb_stb, exit} == 3'b000) else begin
            $display("MISMATCH at %0t: {wb_cyc, wb_stb, exit} got %b expected 000",
                     $time, {wb_cyc, wb_stb, exit});
            test_errors++;
        end
        cycles = 0;
        while (!rst_n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rst_n) begin
            $display("timed out waiting for reset release at %0t", $time);
            test_errors++;
        end
        cycles = 0;
        while (!exit && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!exit) begin
            $display("timed out waiting for exit at %0t", $time);
            test_errors++;
        end else begin
            assert (gp == exp_gp) else begin
                $display("MISMATCH at %0t: gp got %h expected %h", $time, gp, exp_gp);
                test_errors++;
            end
            assert (write_count == exp_writes) else begin
                $display("MISMATCH at %0t: write count got %0d expected %0d",
                         $time, write_count, exp_writes);
                test_errors++;
            end
            for (int i = 0; i < 20; i++) begin
                @(negedge clk);
                assert (!wb_cyc && exit) else begin
                    $display("bus activity or exit drop after exit at %0t", $time);
                    test_errors++;
                end
                assert (gp == exp_gp) else begin
                    $display("MISMATCH at %0t: gp got %h expected %h", $time, gp, exp_gp);
                    test_errors++;
                end
            end
        end
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d program %0d %s waits: %s", tests_run, prog,
                 rnd ? "random" : "zero", (test_errors == 0) ? "PASS" : "FAIL");
    endtask

    initial begin
        reset_req   = 1'b0;
        wb_ack      = 1'b0;
        wb_dat_r    = '0;
        random_wait = 1'b0;
        busy        = 1'b0;
        wait_left   = 0;
        tests_run   = 0;
        tests_failed = 0;
        test_errors = 0;
        write_count = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = NOP;
        end
        for (int p = 0; p < 5; p++) begin
            build_program();
            run_test(p, 1'b0);
            run_test(p, 1'b1);
        end
        $display("%0d tests, %0d passed, %0d failed", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/core_pkg.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/core_top.sv
testbench/tb_clock.sv
testbench/core_asserts.sv
testbench/core_tb.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sim.f --top-module core_tb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vcore_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
